// ==== flist.f ====
source/commit_pkg.sv
source/commit_arb.sv
source/retire_counter.sv
source/commit_stage.sv
dv/commit_stage_properties.sv
dv/commit_stage_tb.sv

// ==== Bender.yml ====
package:
  name: commit_stage

sources:
  - source/commit_pkg.sv
  - source/commit_arb.sv
  - source/retire_counter.sv
  - source/commit_stage.sv
  - target: test
    files:
      - dv/commit_stage_properties.sv
      - dv/commit_stage_tb.sv

// ==== dv/commit_stage_tb.sv ====
// Self-checking testbench for commit_stage; random unit traffic is checked against a model
`timescale 1ns/1ns
`default_nettype none

module commit_stage_tb;

    localparam int ISSUE_WIDTH  = commit_pkg::DEF_ISSUE_WIDTH;
    localparam int NUM_EX_UNITS = commit_pkg::DEF_NUM_EX_UNITS;
    localparam int NUM_THREADS  = commit_pkg::DEF_NUM_THREADS;
    localparam int NUM_WARPS    = commit_pkg::DEF_NUM_WARPS;
    localparam int WID_BITS     = (NUM_WARPS > 1) ? $clog2(NUM_WARPS) : 1;
    localparam int XLEN         = commit_pkg::XLEN;
    localparam int NR_BITS      = commit_pkg::NR_BITS;
    localparam int CTR_BITS     = commit_pkg::PERF_CTR_BITS;
    localparam int NUM_CYCLES   = 2000;
    localparam int RESET_CYCLE  = 1200;
    localparam int DRAIN_CYCLES = 10;
    localparam int WATCHDOG_NS  = 20 * NUM_CYCLES * 10;

    logic clk;
    logic reset;
    logic [ISSUE_WIDTH-1:0][NUM_EX_UNITS-1:0]                            ex_valid;
    logic [ISSUE_WIDTH-1:0][NUM_EX_UNITS-1:0][WID_BITS-1:0]              ex_wid;
    logic [ISSUE_WIDTH-1:0][NUM_EX_UNITS-1:0][NUM_THREADS-1:0]           ex_tmask;
    logic [ISSUE_WIDTH-1:0][NUM_EX_UNITS-1:0][XLEN-1:0]                  ex_pc;
    logic [ISSUE_WIDTH-1:0][NUM_EX_UNITS-1:0]                            ex_wb;
    logic [ISSUE_WIDTH-1:0][NUM_EX_UNITS-1:0][NR_BITS-1:0]               ex_rd;
    logic [ISSUE_WIDTH-1:0][NUM_EX_UNITS-1:0][NUM_THREADS-1:0][XLEN-1:0] ex_data;
    logic [ISSUE_WIDTH-1:0][NUM_EX_UNITS-1:0]                            ex_sop;
    logic [ISSUE_WIDTH-1:0][NUM_EX_UNITS-1:0]                            ex_eop;
    wire  [ISSUE_WIDTH-1:0][NUM_EX_UNITS-1:0]                            ex_ready;
    wire  [ISSUE_WIDTH-1:0]                                              wb_valid;
    wire  [ISSUE_WIDTH-1:0][WID_BITS-1:0]                                wb_wid;
    wire  [ISSUE_WIDTH-1:0][NUM_THREADS-1:0]                             wb_tmask;
    wire  [ISSUE_WIDTH-1:0][XLEN-1:0]                                    wb_pc;
    wire  [ISSUE_WIDTH-1:0][NR_BITS-1:0]                                 wb_rd;
    wire  [ISSUE_WIDTH-1:0][NUM_THREADS-1:0][XLEN-1:0]                   wb_data;
    wire  [ISSUE_WIDTH-1:0]                                              wb_sop;
    wire  [ISSUE_WIDTH-1:0]                                              wb_eop;
    wire  [ISSUE_WIDTH-1:0]                                              committed;
    wire  [ISSUE_WIDTH-1:0][WID_BITS-1:0]                                committed_wid;
    wire  [CTR_BITS-1:0]                                                 instret;

    // reference model state, one entry per slot
    logic [31:0]                                   rng_state;
    int                                            value_errors;
    int                                            checks;
    int                                            last_ptr [ISSUE_WIDTH];
    int                                            acc_unit [ISSUE_WIDTH];
    int                                            ret_pipe [4];
    logic [CTR_BITS-1:0]                           exp_instret;
    logic [ISSUE_WIDTH-1:0]                        exp_valid;
    logic [ISSUE_WIDTH-1:0]                        exp_wb;
    logic [ISSUE_WIDTH-1:0]                        exp_sop;
    logic [ISSUE_WIDTH-1:0]                        exp_eop;
    logic [ISSUE_WIDTH-1:0][WID_BITS-1:0]          exp_wid;
    logic [ISSUE_WIDTH-1:0][NUM_THREADS-1:0]       exp_tmask;
    logic [ISSUE_WIDTH-1:0][XLEN-1:0]              exp_pc;
    logic [ISSUE_WIDTH-1:0][NR_BITS-1:0]           exp_rd;
    logic [ISSUE_WIDTH-1:0][NUM_THREADS-1:0][XLEN-1:0] exp_data;
    logic [ISSUE_WIDTH-1:0]                        comm_exp;
    logic [ISSUE_WIDTH-1:0][WID_BITS-1:0]          comm_wid_exp;
    wire  [31:0]                                   assert_fails [ISSUE_WIDTH];

    commit_stage dut (.*);

    for (genvar s = 0; s < ISSUE_WIDTH; s++) begin : g_assert_count
        assign assert_fails[s] = dut.g_slot[s].u_arb.u_props.fail_count;
    end

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("CHECKS FAILED");
        $finish;
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic string slot_name(input string base, input int s);
        return $sformatf("%s[%0d]", base, s);
    endfunction

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            value_errors++;
            $display("FAIL %s got %h expected %h at %0t ns", name, got, exp, $time);
        end
    endtask

    task automatic check_word(input string name, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] exp);
        checks++;
        if (got !== exp) begin
            value_errors++;
            $display("FAIL %s got %h expected %h at %0t ns", name, got, exp, $time);
        end
    endtask

    task automatic check_wid(input string name, input logic [WID_BITS-1:0] got,
                             input logic [WID_BITS-1:0] exp);
        checks++;
        if (got !== exp) begin
            value_errors++;
            $display("FAIL %s got %h expected %h at %0t ns", name, got, exp, $time);
        end
    endtask

    task automatic check_tmask(input string name, input logic [NUM_THREADS-1:0] got,
                               input logic [NUM_THREADS-1:0] exp);
        checks++;
        if (got !== exp) begin
            value_errors++;
            $display("FAIL %s got %h expected %h at %0t ns", name, got, exp, $time);
        end
    endtask

    task automatic check_rd(input string name, input logic [NR_BITS-1:0] got,
                            input logic [NR_BITS-1:0] exp);
        checks++;
        if (got !== exp) begin
            value_errors++;
            $display("FAIL %s got %h expected %h at %0t ns", name, got, exp, $time);
        end
    endtask

    task automatic check_instret(input string name, input logic [CTR_BITS-1:0] got,
                                 input logic [CTR_BITS-1:0] exp);
        checks++;
        if (got !== exp) begin
            value_errors++;
            $display("FAIL %s got %h expected %h at %0t ns", name, got, exp, $time);
        end
    endtask

    task automatic reset_model();
        for (int s = 0; s < ISSUE_WIDTH; s++) begin
            // unit 0 is searched first after reset
            last_ptr[s] = NUM_EX_UNITS - 1;
            acc_unit[s] = -1;
        end
        exp_valid   = '0;
        comm_exp    = '0;
        exp_instret = '0;
        ret_pipe    = '{default: 0};
    endtask

    // registered outputs after the last rising edge, compared before new inputs go out
    task automatic check_outputs();
        exp_instret = exp_instret + CTR_BITS'(ret_pipe[3]);
        for (int i = 3; i > 0; i--) begin
            ret_pipe[i] = ret_pipe[i-1];
        end
        ret_pipe[0] = 0;
        for (int s = 0; s < ISSUE_WIDTH; s++) begin
            check_bit(slot_name("wb_valid", s), wb_valid[s], exp_valid[s] && exp_wb[s]);
            if (exp_valid[s]) begin
                check_wid(slot_name("wb_wid", s), wb_wid[s], exp_wid[s]);
                check_tmask(slot_name("wb_tmask", s), wb_tmask[s], exp_tmask[s]);
                check_word(slot_name("wb_pc", s), wb_pc[s], exp_pc[s]);
                check_rd(slot_name("wb_rd", s), wb_rd[s], exp_rd[s]);
                check_bit(slot_name("wb_sop", s), wb_sop[s], exp_sop[s]);
                check_bit(slot_name("wb_eop", s), wb_eop[s], exp_eop[s]);
                for (int t = 0; t < NUM_THREADS; t++) begin
                    check_word($sformatf("wb_data[%0d][%0d]", s, t), wb_data[s][t],
                               exp_data[s][t]);
                end
            end
            check_bit(slot_name("committed", s), committed[s], comm_exp[s]);
            if (comm_exp[s]) begin
                check_wid(slot_name("committed_wid", s), committed_wid[s], comm_wid_exp[s]);
            end
        end
        check_instret("instret", instret, exp_instret);
    endtask

    // a unit that is idle or was just accepted may offer a new result, others hold
    task automatic drive_units(input logic raise);
        logic [31:0] r;
        for (int s = 0; s < ISSUE_WIDTH; s++) begin
            for (int u = 0; u < NUM_EX_UNITS; u++) begin
                if (!ex_valid[s][u] || acc_unit[s] == u) begin
                    r = next_random();
                    ex_valid[s][u] = raise && r[31];
                    ex_wb[s][u]    = r[30];
                    ex_sop[s][u]   = r[29];
                    ex_eop[s][u]   = r[28];
                    ex_rd[s][u]    = NR_BITS'(r >> 20);
                    ex_wid[s][u]   = WID_BITS'(r >> 16);
                    ex_tmask[s][u] = NUM_THREADS'(r >> 8);
                    ex_pc[s][u]    = next_random();
                    for (int t = 0; t < NUM_THREADS; t++) begin
                        ex_data[s][u][t] = next_random();
                    end
                end
            end
        end
    endtask

    // round-robin choice from the unit after the last grant, then record what the edge takes
    task automatic grant_and_record();
        int u;
        int cnt;
        cnt = 0;
        for (int s = 0; s < ISSUE_WIDTH; s++) begin
            acc_unit[s] = -1;
            for (int off = 1; off <= NUM_EX_UNITS; off++) begin
                u = (last_ptr[s] + off) % NUM_EX_UNITS;
                if (acc_unit[s] < 0 && ex_valid[s][u]) begin
                    acc_unit[s] = u;
                end
            end
            for (int v = 0; v < NUM_EX_UNITS; v++) begin
                check_bit($sformatf("ex_ready[%0d][%0d]", s, v), ex_ready[s][v],
                          acc_unit[s] == v);
            end
            comm_exp[s]     = exp_valid[s] && exp_eop[s];
            comm_wid_exp[s] = exp_wid[s];
            exp_valid[s]    = acc_unit[s] >= 0;
            if (exp_valid[s]) begin
                u = acc_unit[s];
                last_ptr[s]  = u;
                exp_wid[s]   = ex_wid[s][u];
                exp_tmask[s] = ex_tmask[s][u];
                exp_pc[s]    = ex_pc[s][u];
                exp_wb[s]    = ex_wb[s][u];
                exp_rd[s]    = ex_rd[s][u];
                exp_data[s]  = ex_data[s][u];
                exp_sop[s]   = ex_sop[s][u];
                exp_eop[s]   = ex_eop[s][u];
                cnt += $countones(ex_tmask[s][u]);
            end
        end
        ret_pipe[0] = cnt;
    endtask

    task automatic run_cycle(input logic raise);
        @(negedge clk);
        check_outputs();
        drive_units(raise);
        #1;
        grant_and_record();
    endtask

    task automatic apply_reset();
        @(negedge clk);
        reset    = 1'b1;
        ex_valid = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        reset_model();
    endtask

    initial begin
        int total_asserts;
        reset     = 1'b1;
        ex_valid  = '0;
        ex_wid    = '0;
        ex_tmask  = '0;
        ex_pc     = '0;
        ex_wb     = '0;
        ex_rd     = '0;
        ex_data   = '0;
        ex_sop    = '0;
        ex_eop    = '0;
        rng_state = 32'h72971158;
        value_errors = 0;
        checks       = 0;
        reset_model();
        apply_reset();
        for (int c = 0; c < NUM_CYCLES; c++) begin
            if (c == RESET_CYCLE) begin
                apply_reset();
            end
            run_cycle(1'b1);
        end
        // let held results commit and the instret pipeline empty
        repeat (DRAIN_CYCLES) run_cycle(1'b0);
        total_asserts = 0;
        for (int s = 0; s < ISSUE_WIDTH; s++) begin
            total_asserts += assert_fails[s];
        end
        $display("checks %0d, value errors %0d, assertion failures %0d",
                 checks, value_errors, total_asserts);
        if (value_errors == 0 && total_asserts == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/commit_stage_properties.sv ====
// Handshake and reset assertions for the commit arbiter, bound into every arbiter instance
`timescale 1ns/1ns
`default_nettype none

module commit_stage_properties #(
    parameter int NUM_EX_UNITS = commit_pkg::DEF_NUM_EX_UNITS
) (
    input wire                    clk,
    input wire                    reset,
    input wire [NUM_EX_UNITS-1:0] ex_valid,
    input wire [NUM_EX_UNITS-1:0] ex_ready,
    input wire                    wb_valid,
    input wire                    slot_fire,
    input wire                    committed
);

    // number of assertion failures in this arbiter instance
    int fail_count = 0;

    // at most one unit is granted, and only one that offers a result
    grant_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(ex_ready) && ((ex_ready & ~ex_valid) == '0))
    else begin
        fail_count++;
        $error("ex_ready is not one-hot among the valid units");
    end

    // a grant fills the output register on the next edge
    grant_fills_output: assert property (@(posedge clk) disable iff (reset)
        |ex_ready |=> slot_fire)
    else begin
        fail_count++;
        $error("a granted result did not show up as slot_fire one cycle later");
    end

    // writeback only ever follows a grant on the previous edge
    writeback_after_grant: assert property (@(posedge clk) disable iff (reset)
        wb_valid |-> $past(|ex_ready))
    else begin
        fail_count++;
        $error("wb_valid is high without a grant one cycle earlier");
    end

    // a reset edge clears every output strobe
    reset_clears: assert property (@(posedge clk)
        reset |=> !slot_fire && !wb_valid && !committed)
    else begin
        fail_count++;
        $error("output strobes are not low after a reset edge");
    end

endmodule

bind commit_arb commit_stage_properties #(
    .NUM_EX_UNITS (NUM_EX_UNITS)
) u_props (
    .clk       (clk),
    .reset     (reset),
    .ex_valid  (ex_valid),
    .ex_ready  (ex_ready),
    .wb_valid  (wb_valid),
    .slot_fire (slot_fire),
    .committed (committed)
);

`default_nettype wire

// ==== source/commit_stage.sv ====
// Commit stage top level; one arbiter per issue slot plus the shared retire counter
`timescale 1ns/1ns
`default_nettype none

module commit_stage #(
    parameter int  ISSUE_WIDTH  = commit_pkg::DEF_ISSUE_WIDTH,
    parameter int  NUM_EX_UNITS = commit_pkg::DEF_NUM_EX_UNITS,
    parameter int  NUM_THREADS  = commit_pkg::DEF_NUM_THREADS,
    parameter int  NUM_WARPS    = commit_pkg::DEF_NUM_WARPS,
    localparam int WID_BITS     = (NUM_WARPS > 1) ? $clog2(NUM_WARPS) : 1
) (
    input  wire clk,
    input  wire reset,

    // execution unit results, indexed by slot then unit
    input  wire [ISSUE_WIDTH-1:0][NUM_EX_UNITS-1:0]                   ex_valid,
    input  wire [ISSUE_WIDTH-1:0][NUM_EX_UNITS-1:0][WID_BITS-1:0]     ex_wid,
    input  wire [ISSUE_WIDTH-1:0][NUM_EX_UNITS-1:0][NUM_THREADS-1:0]  ex_tmask,
    input  wire [ISSUE_WIDTH-1:0][NUM_EX_UNITS-1:0][commit_pkg::XLEN-1:0] ex_pc,
    input  wire [ISSUE_WIDTH-1:0][NUM_EX_UNITS-1:0]                   ex_wb,
    input  wire [ISSUE_WIDTH-1:0][NUM_EX_UNITS-1:0][commit_pkg::NR_BITS-1:0] ex_rd,
    input  wire [ISSUE_WIDTH-1:0][NUM_EX_UNITS-1:0][NUM_THREADS-1:0][commit_pkg::XLEN-1:0]
                                                                      ex_data,
    input  wire [ISSUE_WIDTH-1:0][NUM_EX_UNITS-1:0]                   ex_sop,
    input  wire [ISSUE_WIDTH-1:0][NUM_EX_UNITS-1:0]                   ex_eop,
    output wire [ISSUE_WIDTH-1:0][NUM_EX_UNITS-1:0]                   ex_ready,

    // register writeback per slot
    output wire [ISSUE_WIDTH-1:0]                                     wb_valid,
    output wire [ISSUE_WIDTH-1:0][WID_BITS-1:0]                       wb_wid,
    output wire [ISSUE_WIDTH-1:0][NUM_THREADS-1:0]                    wb_tmask,
    output wire [ISSUE_WIDTH-1:0][commit_pkg::XLEN-1:0]               wb_pc,
    output wire [ISSUE_WIDTH-1:0][commit_pkg::NR_BITS-1:0]            wb_rd,
    output wire [ISSUE_WIDTH-1:0][NUM_THREADS-1:0][commit_pkg::XLEN-1:0] wb_data,
    output wire [ISSUE_WIDTH-1:0]                                     wb_sop,
    output wire [ISSUE_WIDTH-1:0]                                     wb_eop,

    // warp scheduler notice per slot
    output wire [ISSUE_WIDTH-1:0]                                     committed,
    output wire [ISSUE_WIDTH-1:0][WID_BITS-1:0]                       committed_wid,

    // performance counter
    output wire [commit_pkg::PERF_CTR_BITS-1:0]                       instret
);

    wire [ISSUE_WIDTH-1:0]                  slot_fire;
    wire [ISSUE_WIDTH-1:0][NUM_THREADS-1:0] slot_tmask;

    // the slots arbitrate independently of each other
    for (genvar s = 0; s < ISSUE_WIDTH; s++) begin : g_slot
        commit_arb #(
            .NUM_EX_UNITS (NUM_EX_UNITS),
            .NUM_THREADS  (NUM_THREADS),
            .NUM_WARPS    (NUM_WARPS)
        ) u_arb (
            .clk           (clk),
            .reset         (reset),
            .ex_valid      (ex_valid[s]),
            .ex_wid        (ex_wid[s]),
            .ex_tmask      (ex_tmask[s]),
            .ex_pc         (ex_pc[s]),
            .ex_wb         (ex_wb[s]),
            .ex_rd         (ex_rd[s]),
            .ex_data       (ex_data[s]),
            .ex_sop        (ex_sop[s]),
            .ex_eop        (ex_eop[s]),
            .ex_ready      (ex_ready[s]),
            .wb_valid      (wb_valid[s]),
            .wb_wid        (wb_wid[s]),
            .wb_tmask      (wb_tmask[s]),
            .wb_pc         (wb_pc[s]),
            .wb_rd         (wb_rd[s]),
            .wb_data       (wb_data[s]),
            .wb_sop        (wb_sop[s]),
            .wb_eop        (wb_eop[s]),
            .slot_fire     (slot_fire[s]),
            .slot_tmask    (slot_tmask[s]),
            .committed     (committed[s]),
            .committed_wid (committed_wid[s])
        );
    end

    // every registered result counts toward instret, with or without writeback
    retire_counter #(
        .ISSUE_WIDTH (ISSUE_WIDTH),
        .NUM_THREADS (NUM_THREADS)
    ) u_retire (
        .clk        (clk),
        .reset      (reset),
        .slot_fire  (slot_fire),
        .slot_tmask (slot_tmask),
        .instret    (instret)
    );

endmodule

`default_nettype wire

// ==== source/retire_counter.sv ====
// Retired instruction counter; sums active threads of all committing slots into instret
`timescale 1ns/1ns
`default_nettype none

module retire_counter #(
    parameter int ISSUE_WIDTH = commit_pkg::DEF_ISSUE_WIDTH,
    parameter int NUM_THREADS = commit_pkg::DEF_NUM_THREADS
) (
    input  wire                                       clk,
    input  wire                                       reset,
    input  wire [ISSUE_WIDTH-1:0]                     slot_fire,
    input  wire [ISSUE_WIDTH-1:0][NUM_THREADS-1:0]    slot_tmask,
    output wire [commit_pkg::PERF_CTR_BITS-1:0]       instret
);

    // one slot retires at most NUM_THREADS lanes, all slots at most ISSUE_WIDTH times that
    localparam int CNT_BITS = $clog2(NUM_THREADS + 1);
    localparam int SUM_BITS = $clog2(ISSUE_WIDTH * NUM_THREADS + 1);

    logic [ISSUE_WIDTH-1:0][CNT_BITS-1:0] cnt;
    logic [ISSUE_WIDTH-1:0][CNT_BITS-1:0] cnt_r;
    logic                                 fire_any_r;
    logic [SUM_BITS-1:0]                  sum;
    logic [SUM_BITS-1:0]                  sum_rr;
    logic                                 fire_any_rr;

    logic [commit_pkg::PERF_CTR_BITS-1:0] instret_r;

    // popcount of each slot's mask, zero when the slot is idle
    always_comb begin
        for (int s = 0; s < ISSUE_WIDTH; s++) begin
            cnt[s] = '0;
            for (int t = 0; t < NUM_THREADS; t++) begin
                cnt[s] = cnt[s] + CNT_BITS'(slot_fire[s] && slot_tmask[s][t]);
            end
        end
    end

    // stage one holds the per-slot counts
    always_ff @(posedge clk) begin
        if (reset) begin
            fire_any_r <= 1'b0;
        end else begin
            fire_any_r <= |slot_fire;
        end
    end

    always_ff @(posedge clk) begin
        cnt_r <= cnt;
    end

    // all slots of one cycle collapse into a single addend
    always_comb begin
        sum = '0;
        for (int s = 0; s < ISSUE_WIDTH; s++) begin
            sum = sum + SUM_BITS'(cnt_r[s]);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fire_any_rr <= 1'b0;
        end else begin
            fire_any_rr <= fire_any_r;
        end
    end

    always_ff @(posedge clk) begin
        sum_rr <= sum;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            instret_r <= '0;
        end else if (fire_any_rr) begin
            instret_r <= instret_r + commit_pkg::PERF_CTR_BITS'(sum_rr);
        end
    end

    assign instret = instret_r;

endmodule

`default_nettype wire

// ==== source/commit_arb.sv ====
// Per-slot commit arbiter; picks one execution unit per cycle round-robin and drives writeback
`timescale 1ns/1ns
`default_nettype none

module commit_arb #(
    parameter int  NUM_EX_UNITS = commit_pkg::DEF_NUM_EX_UNITS,
    parameter int  NUM_THREADS  = commit_pkg::DEF_NUM_THREADS,
    parameter int  NUM_WARPS    = commit_pkg::DEF_NUM_WARPS,
    localparam int WID_BITS     = (NUM_WARPS > 1) ? $clog2(NUM_WARPS) : 1
) (
    input  wire                                                    clk,
    input  wire                                                    reset,

    // results offered by the execution units of this slot
    input  wire [NUM_EX_UNITS-1:0]                                 ex_valid,
    input  wire [NUM_EX_UNITS-1:0][WID_BITS-1:0]                   ex_wid,
    input  wire [NUM_EX_UNITS-1:0][NUM_THREADS-1:0]                ex_tmask,
    input  wire [NUM_EX_UNITS-1:0][commit_pkg::XLEN-1:0]           ex_pc,
    input  wire [NUM_EX_UNITS-1:0]                                 ex_wb,
    input  wire [NUM_EX_UNITS-1:0][commit_pkg::NR_BITS-1:0]        ex_rd,
    input  wire [NUM_EX_UNITS-1:0][NUM_THREADS-1:0][commit_pkg::XLEN-1:0] ex_data,
    input  wire [NUM_EX_UNITS-1:0]                                 ex_sop,
    input  wire [NUM_EX_UNITS-1:0]                                 ex_eop,
    output wire [NUM_EX_UNITS-1:0]                                 ex_ready,

    // register writeback, always accepted
    output wire                                                    wb_valid,
    output wire [WID_BITS-1:0]                                     wb_wid,
    output wire [NUM_THREADS-1:0]                                  wb_tmask,
    output wire [commit_pkg::XLEN-1:0]                             wb_pc,
    output wire [commit_pkg::NR_BITS-1:0]                          wb_rd,
    output wire [NUM_THREADS-1:0][commit_pkg::XLEN-1:0]            wb_data,
    output wire                                                    wb_sop,
    output wire                                                    wb_eop,

    // toward the retire counter
    output wire                                                    slot_fire,
    output wire [NUM_THREADS-1:0]                                  slot_tmask,

    // toward the warp scheduler
    output wire                                                    committed,
    output wire [WID_BITS-1:0]                                     committed_wid
);

    localparam int UNIT_BITS = (NUM_EX_UNITS > 1) ? $clog2(NUM_EX_UNITS) : 1;

    // index of the unit granted last; the search starts one above it
    logic [UNIT_BITS-1:0] last_r;

    logic [NUM_EX_UNITS-1:0] grant;
    logic [UNIT_BITS-1:0]    grant_idx;
    logic                    grant_any;

    // output register of the selected result
    logic                                       valid_r;
    logic [WID_BITS-1:0]                        wid_r;
    logic [NUM_THREADS-1:0]                     tmask_r;
    logic [commit_pkg::XLEN-1:0]                pc_r;
    logic                                       wb_r;
    logic [commit_pkg::NR_BITS-1:0]             rd_r;
    logic [NUM_THREADS-1:0][commit_pkg::XLEN-1:0] data_r;
    logic                                       sop_r;
    logic                                       eop_r;

    // committed notice, one cycle behind the output register
    logic                committed_r;
    logic [WID_BITS-1:0] committed_wid_r;

    // search upward from last_r + 1 and wrap, so the first valid unit found wins
    always_comb begin
        int idx;
        grant     = '0;
        grant_idx = '0;
        grant_any = 1'b0;
        for (int off = 1; off <= NUM_EX_UNITS; off++) begin
            idx = int'(last_r) + off;
            if (idx >= NUM_EX_UNITS) begin
                idx = idx - NUM_EX_UNITS;
            end
            if (!grant_any && ex_valid[idx]) begin
                grant_any = 1'b1;
                grant_idx = UNIT_BITS'(idx);
            end
        end
        if (grant_any) begin
            grant[grant_idx] = 1'b1;
        end
    end

    // the output register never stalls, so the grant is the ready
    assign ex_ready = grant;

    always_ff @(posedge clk) begin
        if (reset) begin
            // pointing at the top unit makes unit 0 the first one searched
            last_r <= UNIT_BITS'(NUM_EX_UNITS - 1);
        end else if (grant_any) begin
            last_r <= grant_idx;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_r <= 1'b0;
        end else begin
            valid_r <= grant_any;
        end
    end

    always_ff @(posedge clk) begin
        if (grant_any) begin
            wid_r   <= ex_wid[grant_idx];
            tmask_r <= ex_tmask[grant_idx];
            pc_r    <= ex_pc[grant_idx];
            wb_r    <= ex_wb[grant_idx];
            rd_r    <= ex_rd[grant_idx];
            data_r  <= ex_data[grant_idx];
            sop_r   <= ex_sop[grant_idx];
            eop_r   <= ex_eop[grant_idx];
        end
    end

    // results without a destination register still commit, they just skip writeback
    assign wb_valid = valid_r && wb_r;
    assign wb_wid   = wid_r;
    assign wb_tmask = tmask_r;
    assign wb_pc    = pc_r;
    assign wb_rd    = rd_r;
    assign wb_data  = data_r;
    assign wb_sop   = sop_r;
    assign wb_eop   = eop_r;

    assign slot_fire  = valid_r;
    assign slot_tmask = tmask_r;

    // only the last packet of an instruction tells the scheduler the warp is done
    always_ff @(posedge clk) begin
        if (reset) begin
            committed_r <= 1'b0;
        end else begin
            committed_r <= valid_r && eop_r;
        end
    end

    always_ff @(posedge clk) begin
        committed_wid_r <= wid_r;
    end

    assign committed     = committed_r;
    assign committed_wid = committed_wid_r;

endmodule

`default_nettype wire

// ==== source/commit_pkg.sv ====
// Shared widths and constants for the commit stage; RTL and testbench refer to them by scoped name
`default_nettype none

package commit_pkg;

    // data word width of one thread lane, also used for the PC
    localparam int XLEN = 32;

    // register index width of the writeback port
    localparam int NR_BITS = 5;

    // width of the retired instruction counter
    localparam int PERF_CTR_BITS = 44;

    // default number of issue slots, each with its own commit arbiter
    localparam int DEF_ISSUE_WIDTH = 2;

    // default number of execution units feeding one slot
    localparam int DEF_NUM_EX_UNITS = 3;

    // default number of threads per warp, which is also the thread mask width
    localparam int DEF_NUM_THREADS = 4;

    // default number of warps
    // the warp ID width is derived from this inside each module
    localparam int DEF_NUM_WARPS = 4;

    // unit positions on the arbiter inputs
    // with the round-robin pointer reset, the ALU is searched first
    localparam int EX_ALU = 0;

    localparam int EX_LSU = 1;

    localparam int EX_SFU = 2;

endpackage

`default_nettype wire
